// File: mem_endpoint.f
verilog/mem_endpoint_pkg.sv
verilog/mem_one_fifo.sv
verilog/mem_fwd_decode.sv
verilog/mem_scratch_exec.sv
verilog/mem_loopback.sv
verilog/mem_rev_merge.sv
verilog/mem_endpoint.sv
tests/mem_endpoint_asserts.sv
tests/mem_endpoint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the endpoint testbench with Verilator and runs it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_endpoint_tb \
  -f mem_endpoint.f \
  -o mem_endpoint_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/mem_endpoint_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

// File: tests/mem_endpoint_asserts.sv
`timescale 1ns/10ps

module mem_endpoint_asserts (
  input logic                                     clk_i,
  input logic                                     rst_n_i,

  input logic                                     rev_v_i,
  input logic                                     rev_ready_i,
  input mem_endpoint_pkg::mem_header_t            rev_header_i,
  input logic [mem_endpoint_pkg::dword_width-1:0] rev_data_i,

  input mem_endpoint_pkg::mem_route_e             route_i,
  input logic                                     route_v_i,
  input logic                                     lpb_rsp_v_i,
  input logic                                     lpb_rsp_yumi_i
);

  // The reverse port stays quiet while the endpoint is held in reset
  rev_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !rev_v_i)
    else $error("mem_rev_v_o is high during reset");

  // A stalled response keeps its valid, header and data until it moves
  rev_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_i && !rev_ready_i |=> rev_v_i && $stable(rev_header_i) && $stable(rev_data_i))
    else $error("reverse response changed while stalled");

  // A tie-off response leaves the reverse port with an empty payload
  rev_tie_off_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lpb_rsp_yumi_i |-> rev_data_i == '0)
    else $error("tie-off response carries a nonzero payload");

  // A request steered to the tie-off is answered in the next cycle
  tie_off_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    route_v_i && route_i == mem_endpoint_pkg::e_route_loopback |=> lpb_rsp_v_i)
    else $error("tie-off response did not follow its request");

endmodule

bind mem_endpoint mem_endpoint_asserts protocol_checks (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .rev_v_i       (mem_rev_v_o),
  .rev_ready_i   (mem_rev_ready_and_i),
  .rev_header_i  (mem_rev_header_o),
  .rev_data_i    (mem_rev_data_o),
  .route_i       (route),
  .route_v_i     (route_v),
  .lpb_rsp_v_i   (lpb_rsp_v),
  .lpb_rsp_yumi_i(lpb_rsp_yumi)
);

// File: tests/mem_endpoint_tb.sv
`timescale 1ns/10ps

module mem_endpoint_tb;

  localparam int n_stim         = 24;
  // Entries below this index run with the reverse port always ready
  localparam int n_direct       = 13;
  localparam int timeout_cycles = 20 * n_stim + 100;

  localparam mem_endpoint_pkg::mem_msg_e rd_op    = mem_endpoint_pkg::e_mem_rd;
  localparam mem_endpoint_pkg::mem_msg_e wr_op    = mem_endpoint_pkg::e_mem_wr;
  localparam mem_endpoint_pkg::mem_msg_e rsvd2_op = mem_endpoint_pkg::e_mem_rsvd2;
  localparam mem_endpoint_pkg::mem_msg_e rsvd3_op = mem_endpoint_pkg::e_mem_rsvd3;

  typedef logic [mem_endpoint_pkg::dword_width-1:0] dword_t;

  typedef struct packed {
    mem_endpoint_pkg::mem_header_t header;
    dword_t                        data;
  } stim_t;

  logic                          clk_i;
  logic                          rst_n_i;
  mem_endpoint_pkg::mem_header_t mem_fwd_header_i;
  dword_t                        mem_fwd_data_i;
  logic                          mem_fwd_v_i;
  logic                          mem_fwd_ready_and_o;
  mem_endpoint_pkg::mem_header_t mem_rev_header_o;
  dword_t                        mem_rev_data_o;
  logic                          mem_rev_v_o;
  logic                          mem_rev_ready_and_i;

  stim_t                         stim [n_stim];
  dword_t                        model_mem [mem_endpoint_pkg::scratch_words];
  mem_endpoint_pkg::mem_header_t exp_header_q [$];
  dword_t                        exp_data_q [$];
  int                            exp_cycle_q [$];

  logic [31:0] lcg_state     = 32'h66f5_d476;
  int          timeout_count = 0;
  int          cycle;
  int          idx;
  logic        random_bp;

  mem_endpoint dut (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .mem_fwd_header_i   (mem_fwd_header_i),
    .mem_fwd_data_i     (mem_fwd_data_i),
    .mem_fwd_v_i        (mem_fwd_v_i),
    .mem_fwd_ready_and_o(mem_fwd_ready_and_o),
    .mem_rev_header_o   (mem_rev_header_o),
    .mem_rev_data_o     (mem_rev_data_o),
    .mem_rev_v_o        (mem_rev_v_o),
    .mem_rev_ready_and_i(mem_rev_ready_and_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers and checks
  // --------------------------------------------------------------------------

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_header(string name, mem_endpoint_pkg::mem_header_t got,
                              mem_endpoint_pkg::mem_header_t exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(string name, dword_t got, dword_t exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Ready is high about three cycles out of four
  function automatic logic next_ready();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:30] != 2'b00;
  endfunction

  function automatic stim_t entry(mem_endpoint_pkg::mem_msg_e msg, logic [19:0] addr,
                                  logic [3:0] src, dword_t data);
    stim_t s;
    s.header.msg_type = msg;
    s.header.addr     = addr;
    s.header.src_id   = src;
    s.data            = data;
    return s;
  endfunction

  // Only reads and writes below byte address 0x200 reach the model memory
  task automatic expect_response(stim_t s, int at_cycle);
    logic       in_mem;
    logic [5:0] word;
    dword_t     rsp;
    in_mem = (s.header.msg_type == rd_op || s.header.msg_type == wr_op) &&
             s.header.addr[19:9] == 11'h000;
    word   = s.header.addr[8:3];
    rsp    = '0;
    if (in_mem && s.header.msg_type == wr_op) begin
      model_mem[word] = s.data;
    end else if (in_mem) begin
      rsp = model_mem[word];
    end
    exp_header_q.push_back(s.header);
    exp_data_q.push_back(rsp);
    exp_cycle_q.push_back(at_cycle);
  endtask

  task automatic check_response();
    mem_endpoint_pkg::mem_header_t hdr;
    dword_t                        data;
    int                            at_cycle;
    if (exp_header_q.size() == 0) begin
      $display("A response came back with no request outstanding");
      abort_run();
    end
    hdr      = exp_header_q.pop_front();
    data     = exp_data_q.pop_front();
    at_cycle = exp_cycle_q.pop_front();
    check_header("mem_rev_header_o", mem_rev_header_o, hdr);
    check_data("mem_rev_data_o", mem_rev_data_o, data);
    if (at_cycle >= 0 && at_cycle != cycle) begin
      $display("Response came back in cycle %0d instead of cycle %0d", cycle, at_cycle);
      abort_run();
    end
  endtask

  task automatic load_table();
    // Writes, reads back, out-of-range and reserved requests
    stim[0]  = entry(wr_op,    20'h00000, 4'h1, 64'h0123_4567_89ab_cdef);
    stim[1]  = entry(wr_op,    20'h00008, 4'h2, 64'hfedc_ba98_7654_3210);
    stim[2]  = entry(wr_op,    20'h001f8, 4'h3, 64'h5a5a_a5a5_0f0f_f0f0);
    stim[3]  = entry(rd_op,    20'h00000, 4'h4, 64'h0);
    stim[4]  = entry(rd_op,    20'h00008, 4'h5, 64'h0);
    stim[5]  = entry(rd_op,    20'h001f8, 4'h6, 64'h0);
    stim[6]  = entry(wr_op,    20'h00200, 4'h7, 64'hdead_beef_dead_beef);
    stim[7]  = entry(wr_op,    20'h80008, 4'h8, 64'hcafe_f00d_cafe_f00d);
    stim[8]  = entry(rd_op,    20'h00000, 4'h9, 64'h0);
    stim[9]  = entry(rsvd2_op, 20'h00008, 4'ha, 64'h1111_2222_3333_4444);
    stim[10] = entry(rsvd3_op, 20'h001f8, 4'hb, 64'h9999_8888_7777_6666);
    stim[11] = entry(rd_op,    20'h00008, 4'hc, 64'h0);
    stim[12] = entry(rd_op,    20'h001f8, 4'hd, 64'h0);
    // Mixed traffic under reverse back-pressure
    stim[13] = entry(wr_op,    20'h00010, 4'h1, 64'h0000_1111_2222_3333);
    stim[14] = entry(rd_op,    20'h40000, 4'h2, 64'h0);
    stim[15] = entry(wr_op,    20'h00018, 4'h3, 64'h4444_5555_6666_7777);
    stim[16] = entry(rsvd2_op, 20'h00010, 4'h4, 64'h8888_9999_aaaa_bbbb);
    stim[17] = entry(rd_op,    20'h00010, 4'h5, 64'h0);
    stim[18] = entry(rd_op,    20'h00018, 4'h6, 64'h0);
    stim[19] = entry(wr_op,    20'h00010, 4'h7, 64'hcccc_dddd_eeee_ffff);
    stim[20] = entry(rd_op,    20'h00000, 4'h8, 64'h0);
    stim[21] = entry(rd_op,    20'h00010, 4'h9, 64'h0);
    stim[22] = entry(rd_op,    20'h0fff8, 4'ha, 64'h0);
    stim[23] = entry(rsvd3_op, 20'h00000, 4'hb, 64'h0);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and response checking
  // --------------------------------------------------------------------------

  always @(posedge clk_i) begin
    timeout_count <= timeout_count + 1;
    if (timeout_count >= timeout_cycles) begin
      $display("Timeout: responses still missing after %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  initial begin
    mem_fwd_header_i    = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b1;
    rst_n_i             = 1'b0;
    random_bp           = 1'b0;
    cycle               = 0;
    idx                 = 0;
    load_table();

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_flag("mem_rev_v_o", mem_rev_v_o, 1'b0);
    check_flag("mem_fwd_ready_and_o", mem_fwd_ready_and_o, 1'b1);

    while (idx < n_stim || exp_header_q.size() != 0) begin
      if (mem_rev_v_o && mem_rev_ready_and_i) begin
        check_response();
      end
      // With the reverse port always ready the response is due one cycle later
      if (mem_fwd_v_i && mem_fwd_ready_and_o) begin
        expect_response(stim[idx], random_bp ? -1 : cycle + 1);
        idx++;
      end
      if (idx >= n_direct && exp_header_q.size() == 0) begin
        random_bp = 1'b1;
      end
      if (idx < n_stim && (idx < n_direct || random_bp)) begin
        mem_fwd_header_i <= stim[idx].header;
        mem_fwd_data_i   <= stim[idx].data;
        mem_fwd_v_i      <= 1'b1;
      end else begin
        mem_fwd_v_i <= 1'b0;
      end
      if (random_bp) begin
        mem_rev_ready_and_i <= next_ready();
      end
      @(posedge clk_i);
      cycle++;
    end

    // Every request has been answered, so the reverse port stays idle
    repeat (4) begin
      @(posedge clk_i);
      check_flag("mem_rev_v_o", mem_rev_v_o, 1'b0);
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: verilog/mem_endpoint.sv
`timescale 1ns/10ps

module mem_endpoint (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  mem_endpoint_pkg::mem_header_t            mem_fwd_header_i,
  input  logic [mem_endpoint_pkg::dword_width-1:0] mem_fwd_data_i,
  input  logic                                     mem_fwd_v_i,
  output logic                                     mem_fwd_ready_and_o,

  output mem_endpoint_pkg::mem_header_t            mem_rev_header_o,
  output logic [mem_endpoint_pkg::dword_width-1:0] mem_rev_data_o,
  output logic                                     mem_rev_v_o,
  input  logic                                     mem_rev_ready_and_i
);

  // Decoder to executors
  mem_endpoint_pkg::mem_header_t            scr_req_header;
  logic [mem_endpoint_pkg::dword_width-1:0] scr_req_data;
  logic                                     scr_req_v;
  logic                                     scr_req_ready;
  mem_endpoint_pkg::mem_header_t            lpb_req_header;
  logic                                     lpb_req_v;
  logic                                     lpb_req_ready;

  // Decoder to merger
  mem_endpoint_pkg::mem_route_e             route;
  logic                                     route_v;
  logic                                     route_ready;

  // Executors to merger
  mem_endpoint_pkg::mem_header_t            scr_rsp_header;
  logic [mem_endpoint_pkg::dword_width-1:0] scr_rsp_data;
  logic                                     scr_rsp_v;
  logic                                     scr_rsp_yumi;
  mem_endpoint_pkg::mem_header_t            lpb_rsp_header;
  logic [mem_endpoint_pkg::dword_width-1:0] lpb_rsp_data;
  logic                                     lpb_rsp_v;
  logic                                     lpb_rsp_yumi;

  mem_fwd_decode decode (
    .fwd_header_i (mem_fwd_header_i),
    .fwd_data_i   (mem_fwd_data_i),
    .fwd_v_i      (mem_fwd_v_i),
    .fwd_ready_o  (mem_fwd_ready_and_o),
    .scr_header_o (scr_req_header),
    .scr_data_o   (scr_req_data),
    .scr_v_o      (scr_req_v),
    .scr_ready_i  (scr_req_ready),
    .lpb_header_o (lpb_req_header),
    .lpb_v_o      (lpb_req_v),
    .lpb_ready_i  (lpb_req_ready),
    .route_o      (route),
    .route_v_o    (route_v),
    .route_ready_i(route_ready)
  );

  mem_scratch_exec scratch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_header_i(scr_req_header),
    .req_data_i  (scr_req_data),
    .req_v_i     (scr_req_v),
    .req_ready_o (scr_req_ready),
    .rsp_header_o(scr_rsp_header),
    .rsp_data_o  (scr_rsp_data),
    .rsp_v_o     (scr_rsp_v),
    .rsp_yumi_i  (scr_rsp_yumi)
  );

  mem_loopback loopback (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_header_i(lpb_req_header),
    .req_v_i     (lpb_req_v),
    .req_ready_o (lpb_req_ready),
    .rsp_header_o(lpb_rsp_header),
    .rsp_data_o  (lpb_rsp_data),
    .rsp_v_o     (lpb_rsp_v),
    .rsp_yumi_i  (lpb_rsp_yumi)
  );

  mem_rev_merge merge (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .route_i      (route),
    .route_v_i    (route_v),
    .route_ready_o(route_ready),
    .scr_header_i (scr_rsp_header),
    .scr_data_i   (scr_rsp_data),
    .scr_v_i      (scr_rsp_v),
    .scr_yumi_o   (scr_rsp_yumi),
    .lpb_header_i (lpb_rsp_header),
    .lpb_data_i   (lpb_rsp_data),
    .lpb_v_i      (lpb_rsp_v),
    .lpb_yumi_o   (lpb_rsp_yumi),
    .rev_header_o (mem_rev_header_o),
    .rev_data_o   (mem_rev_data_o),
    .rev_v_o      (mem_rev_v_o),
    .rev_ready_i  (mem_rev_ready_and_i)
  );

endmodule

// File: verilog/mem_endpoint_pkg.sv
package mem_endpoint_pkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------

  localparam int dword_width        = 64;
  localparam int paddr_width        = 20;
  localparam int src_id_width       = 4;
  localparam int scratch_words      = 64;
  localparam int scratch_idx_width  = 6;
  // Byte offset inside one dword
  localparam int dword_offset_width = 3;

  // Route-order queue in the merger
  localparam int order_depth     = 4;
  localparam int order_ptr_width = 2;
  localparam int order_cnt_width = 3;
  localparam logic [order_cnt_width-1:0] order_depth_cnt = order_cnt_width'(order_depth);

  // ------------------------------------------------------------------------
  // Message types and header
  // ------------------------------------------------------------------------

  // The reserved encodings never reach the scratch memory
  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_rsvd2 = 2'b10,
    e_mem_rsvd3 = 2'b11
  } mem_msg_e;

  typedef struct packed {
    mem_msg_e                  msg_type;
    logic [paddr_width-1:0]    addr;
    logic [src_id_width-1:0]   src_id;
  } mem_header_t;

  // Response held in the scratch executor buffer
  typedef struct packed {
    mem_header_t               header;
    logic [dword_width-1:0]    data;
  } mem_scratch_rsp_t;

  typedef enum logic {
    e_route_scratch  = 1'b0,
    e_route_loopback = 1'b1
  } mem_route_e;

  // An address hits the scratch memory when every bit above the index is zero
  function automatic logic in_scratch_range(logic [paddr_width-1:0] addr);
    return addr[paddr_width-1:scratch_idx_width+dword_offset_width] == '0;
  endfunction

  function automatic logic [scratch_idx_width-1:0] scratch_index(logic [paddr_width-1:0] addr);
    return addr[scratch_idx_width+dword_offset_width-1:dword_offset_width];
  endfunction

endpackage

// File: verilog/mem_fwd_decode.sv
`timescale 1ns/10ps

module mem_fwd_decode (
  // Forward request from the top
  input  mem_endpoint_pkg::mem_header_t            fwd_header_i,
  input  logic [mem_endpoint_pkg::dword_width-1:0] fwd_data_i,
  input  logic                                     fwd_v_i,
  output logic                                     fwd_ready_o,

  // Scratch memory link
  output mem_endpoint_pkg::mem_header_t            scr_header_o,
  output logic [mem_endpoint_pkg::dword_width-1:0] scr_data_o,
  output logic                                     scr_v_o,
  input  logic                                     scr_ready_i,

  // Tie-off link carries no payload
  output mem_endpoint_pkg::mem_header_t            lpb_header_o,
  output logic                                     lpb_v_o,
  input  logic                                     lpb_ready_i,

  // Route tag into the merger order queue
  output mem_endpoint_pkg::mem_route_e             route_o,
  output logic                                     route_v_o,
  input  logic                                     route_ready_i
);

  logic is_mem_op;
  logic to_scratch;
  logic path_ready;
  logic issue;

  // ------------------------------------------------------------------------
  // Classification
  // ------------------------------------------------------------------------

  assign is_mem_op = (fwd_header_i.msg_type == mem_endpoint_pkg::e_mem_rd) ||
                     (fwd_header_i.msg_type == mem_endpoint_pkg::e_mem_wr);

  assign to_scratch = is_mem_op && mem_endpoint_pkg::in_scratch_range(fwd_header_i.addr);

  assign route_o = to_scratch ? mem_endpoint_pkg::e_route_scratch
                              : mem_endpoint_pkg::e_route_loopback;

  // ------------------------------------------------------------------------
  // Steering
  // ------------------------------------------------------------------------

  // Ready looks at the header only, never at valid
  assign path_ready  = to_scratch ? scr_ready_i : lpb_ready_i;
  assign fwd_ready_o = path_ready && route_ready_i;

  // The executor and the order queue take the request in the same cycle
  assign issue = fwd_v_i && fwd_ready_o;

  assign scr_v_o   = issue && to_scratch;
  assign lpb_v_o   = issue && !to_scratch;
  assign route_v_o = issue;

  assign scr_header_o = fwd_header_i;
  assign scr_data_o   = fwd_data_i;
  assign lpb_header_o = fwd_header_i;

endmodule

// File: verilog/mem_loopback.sv
`timescale 1ns/10ps

module mem_loopback (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  mem_endpoint_pkg::mem_header_t            req_header_i,
  input  logic                                     req_v_i,
  output logic                                     req_ready_o,

  output mem_endpoint_pkg::mem_header_t            rsp_header_o,
  output logic [mem_endpoint_pkg::dword_width-1:0] rsp_data_o,
  output logic                                     rsp_v_o,
  input  logic                                     rsp_yumi_i
);

  // Bad addresses and reserved types drain here so the network
  // never waits on a request that has no real target
  mem_one_fifo #(
    .payload_t(mem_endpoint_pkg::mem_header_t)
  ) echo_buffer (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),

    .data_i (req_header_i),
    .v_i    (req_v_i),
    .ready_o(req_ready_o),

    .data_o (rsp_header_o),
    .v_o    (rsp_v_o),
    .yumi_i (rsp_yumi_i)
  );

  // The echoed header always comes back with an empty payload
  assign rsp_data_o = '0;

endmodule

// File: verilog/mem_one_fifo.sv
`timescale 1ns/10ps

module mem_one_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  logic     full_q;
  payload_t data_q;

  // Only an empty buffer takes a new entry, so the input side never
  // sees the output side within one cycle
  assign ready_o = ~full_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (v_i && ready_o) begin
      full_q <= 1'b1;
    end else if (yumi_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;
  assign v_o    = full_q;

endmodule

// File: verilog/mem_rev_merge.sv
`timescale 1ns/10ps

module mem_rev_merge (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  mem_endpoint_pkg::mem_route_e             route_i,
  input  logic                                     route_v_i,
  output logic                                     route_ready_o,

  input  mem_endpoint_pkg::mem_header_t            scr_header_i,
  input  logic [mem_endpoint_pkg::dword_width-1:0] scr_data_i,
  input  logic                                     scr_v_i,
  output logic                                     scr_yumi_o,

  input  mem_endpoint_pkg::mem_header_t            lpb_header_i,
  input  logic [mem_endpoint_pkg::dword_width-1:0] lpb_data_i,
  input  logic                                     lpb_v_i,
  output logic                                     lpb_yumi_o,

  output mem_endpoint_pkg::mem_header_t            rev_header_o,
  output logic [mem_endpoint_pkg::dword_width-1:0] rev_data_o,
  output logic                                     rev_v_o,
  input  logic                                     rev_ready_i
);

  mem_endpoint_pkg::mem_route_e order_q [mem_endpoint_pkg::order_depth];

  logic [mem_endpoint_pkg::order_ptr_width-1:0] wr_ptr_q;
  logic [mem_endpoint_pkg::order_ptr_width-1:0] rd_ptr_q;
  logic [mem_endpoint_pkg::order_cnt_width-1:0] count_q;

  mem_endpoint_pkg::mem_route_e head;
  logic                         not_empty;
  logic                         push;
  logic                         pop;

  // ------------------------------------------------------------------------
  // Route-order queue
  // ------------------------------------------------------------------------

  assign route_ready_o = count_q != mem_endpoint_pkg::order_depth_cnt;
  assign not_empty     = count_q != '0;
  assign head          = order_q[rd_ptr_q];

  assign push = route_v_i && route_ready_o;
  assign pop  = rev_v_o && rev_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= route_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Response select
  // ------------------------------------------------------------------------

  // Only the path named at the head may drive the reverse port
  always_comb begin
    if (head == mem_endpoint_pkg::e_route_scratch) begin
      rev_header_o = scr_header_i;
      rev_data_o   = scr_data_i;
      rev_v_o      = not_empty && scr_v_i;
    end else begin
      rev_header_o = lpb_header_i;
      rev_data_o   = lpb_data_i;
      rev_v_o      = not_empty && lpb_v_i;
    end
  end

  assign scr_yumi_o = pop && (head == mem_endpoint_pkg::e_route_scratch);
  assign lpb_yumi_o = pop && (head == mem_endpoint_pkg::e_route_loopback);

endmodule

// File: verilog/mem_scratch_exec.sv
`timescale 1ns/10ps

module mem_scratch_exec (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  mem_endpoint_pkg::mem_header_t            req_header_i,
  input  logic [mem_endpoint_pkg::dword_width-1:0] req_data_i,
  input  logic                                     req_v_i,
  output logic                                     req_ready_o,

  output mem_endpoint_pkg::mem_header_t            rsp_header_o,
  output logic [mem_endpoint_pkg::dword_width-1:0] rsp_data_o,
  output logic                                     rsp_v_o,
  input  logic                                     rsp_yumi_i
);

  logic [mem_endpoint_pkg::dword_width-1:0] mem_q [mem_endpoint_pkg::scratch_words];

  logic [mem_endpoint_pkg::scratch_idx_width-1:0] idx;
  logic                                           is_write;
  logic                                           req_xfer;

  mem_endpoint_pkg::mem_scratch_rsp_t rsp_in;
  mem_endpoint_pkg::mem_scratch_rsp_t rsp_out;

  // ------------------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------------------

  assign idx      = mem_endpoint_pkg::scratch_index(req_header_i.addr);
  assign is_write = req_header_i.msg_type == mem_endpoint_pkg::e_mem_wr;
  assign req_xfer = req_v_i && req_ready_o;

  // The array is written at the same edge that loads the response buffer
  always_ff @(posedge clk_i) begin
    if (req_xfer && is_write) begin
      mem_q[idx] <= req_data_i;
    end
  end

  // A read captures the stored dword at the transfer edge, a write
  // answers with a zero payload
  always_comb begin
    rsp_in.header = req_header_i;
    if (is_write) begin
      rsp_in.data = '0;
    end else begin
      rsp_in.data = mem_q[idx];
    end
  end

  // ------------------------------------------------------------------------
  // Response buffer
  // ------------------------------------------------------------------------

  mem_one_fifo #(
    .payload_t(mem_endpoint_pkg::mem_scratch_rsp_t)
  ) rsp_buffer (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),

    .data_i (rsp_in),
    .v_i    (req_v_i),
    .ready_o(req_ready_o),

    .data_o (rsp_out),
    .v_o    (rsp_v_o),
    .yumi_i (rsp_yumi_i)
  );

  assign rsp_header_o = rsp_out.header;
  assign rsp_data_o   = rsp_out.data;

endmodule
